//--- tb.f
+incdir+design
design/main_pkg.sv
design/cpu_bus_if.sv
design/addr_decode.sv
design/io_regs.sv
design/read_mux.sv
design/main_board.sv
test/main_board_tb.sv

//--- Makefile
TOP = main_board_tb

all: run

compile:
	verilator --binary -f tb.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	grep -q "RESULT: PASS" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean

//--- test/main_board_tb.sv
`default_nettype none

`include "main_cfg.svh"

module main_board_tb;
    import main_pkg::*;

    localparam int N_ACC = 250;     // Two-cycle bus accesses per phase
    localparam int LIMIT = 4 * N_ACC * 2 + 5 + 100;

    logic                    clk, rst, rst8;
    board_t                  board;
    logic                    cpu_cen, cpu_we, rom_ok, service;
    logic [`MAIN_AW-1:0]     cpu_addr;
    logic [7:0]              cpu_aupper;
    logic [`MAIN_DW-1:0]     cpu_dout, rom_data, ram_dout, pal_dout, tilesys_dout, objsys_dout;
    logic [3:0]              coin, cab_1p;
    logic [`MAIN_JOY_W-1:0]  joystick1, joystick2;
    logic [19:0]             dipsw;

    logic [`MAIN_DW-1:0]     cpu_din, snd_latch;
    logic [`MAIN_ROM_AW-1:0] rom_addr;
    logic                    dtack, rom_cs, ram_we, pal_we, tilesys_cs, objsys_cs;
    logic                    init, rmrd, snd_irq;
    logic [1:0]              prio;

    // Reference model of the board latches
    logic                    m_init, m_rmrd, m_work, m_irq, m_busrst;
    logic [3:0]              m_bank;
    logic [1:0]              m_prio;
    logic [7:0]              m_latch, m_port;

    integer seed = 32'hb538_f476;
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;

    main_board DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic check_sel(input chip_sel_t exp);
        logic [4:0] got;
        logic [4:0] want;
        got  = {rom_cs, tilesys_cs, objsys_cs, ram_we, pal_we};
        want = {exp.rom, exp.tile, exp.obj, exp.ram & cpu_we, exp.pal & cpu_we};
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: rom/tile/obj/ram_we/pal_we are %b, expected %b",
                     $time, got, want);
        end
        if ($countones(got) > 1) begin
            errors++;
            $display("Mismatch at %0t: more than one select active at %h", $time, cpu_addr);
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string label);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, label, got, exp);
        end
    endtask

    task automatic check_rom(input logic [17:0] exp);
        checks++;
        if (rom_addr !== exp) begin
            errors++;
            $display("Mismatch at %0t: rom_addr is %h, expected %h for address %h",
                     $time, rom_addr, exp, cpu_addr);
        end
    endtask

    // Memory maps written as address ranges
    function automatic chip_sel_t model_sel();
        chip_sel_t   s;
        logic [15:0] a;
        a = cpu_addr;
        s = '0;
        if (board == ALIENS) begin
            s.rom  = a >= 16'h8000 || (a >= 16'h2000 && a <= 16'h3fff);
            s.pal  = a <= 16'h03ff && m_work;
            s.ram  = a <= 16'h1fff && !s.pal;
            s.io   = a >= 16'h5f80 && a <= 16'h5f9f;
            s.obj  = a >= 16'h7800 && a <= 16'h7fff && a[10] && m_init && !m_rmrd;
            s.tile = a >= 16'h4000 && a <= 16'h7fff && (!m_init || (!s.io && !s.obj));
        end else begin
            s.rom  = a >= 16'h8000 || (a >= 16'h6000 && a <= 16'h7fff && m_init);
            s.pal  = a >= 16'h5800 && a <= 16'h5fff && !m_work;
            s.ram  = a >= 16'h4000 && a <= 16'h5fff && !s.pal;
            s.io   = a >= 16'h1f80 && a <= 16'h1fff;
            s.obj  = a >= 16'h3c00 && a <= 16'h3fff && !m_rmrd;
            s.tile = (a <= 16'h3fff && !s.io && !s.obj) ||
                     (a >= 16'h6000 && a <= 16'h7fff && !m_init);
        end
        if (m_busrst) s.rom = 1'b0;     // Bus held by the combined reset
        return s;
    endfunction

    function automatic logic [17:0] model_rom(input chip_sel_t s);
        logic [17:0] r;
        logic [15:0] a;
        a = cpu_addr;
        if (board == ALIENS) begin
            r = (a >= 16'h2000 && a <= 16'h3fff) ? {cpu_aupper[4:0], a[12:0]} : {2'b10, a};
        end else if (a >= 16'h6000 && a <= 16'h7fff && m_init) begin
            r = {1'b0, m_bank[3], m_bank[3] ? m_bank[2] : a[15], m_bank[1:0], a[12:0]};
        end else begin
            r = {2'b00, a};
        end
        if (!s.rom) r[15:0] = a;
        return r;
    endfunction

    function automatic logic [7:0] model_din(input chip_sel_t s);
        if (s.rom) return rom_data;
        if (s.ram) return ram_dout;
        if (s.io) return m_port;       // Captured on the previous edge
        if (s.pal) return pal_dout;
        if (s.tile) return tilesys_dout;
        if (s.obj) return objsys_dout;
        return 8'hff;
    endfunction

    // Register effects of this cycle show after the next edge
    task automatic update_model(input chip_sel_t s);
        logic [3:0] off;
        off = cpu_addr[3:0];
        if (cpu_cen) m_irq = 1'b0;
        if (s.io && board == ALIENS && cpu_we) begin
            if (off == 4'h8) {m_init, m_rmrd, m_work} = cpu_dout[7:5];
            if (off == 4'hc) begin
                m_latch = cpu_dout;
                m_irq   = 1'b1;
            end
        end else if (s.io && board == ALIENS) begin
            case (off)
                4'h0:    m_port = {3'b111, service, dipsw[19:16]};
                4'h1:    m_port = {cab_1p[0], coin[0], joystick1[5:0]};
                4'h2:    m_port = {cab_1p[1], coin[1], joystick2[5:0]};
                4'h3:    m_port = dipsw[15:8];
                4'h4:    m_port = dipsw[7:0];
                default: m_port = 8'hff;
            endcase
        end else if (s.io && !cpu_addr[5]) begin   // Super Contra on any access
            case (cpu_addr[4:2])
                3'd0: begin
                    m_prio = {1'b0, cpu_dout[7]};
                    m_work = cpu_dout[4];
                    m_bank = cpu_dout[3:0];
                end
                3'd1: m_latch = cpu_dout;
                3'd2: m_irq = 1'b1;
                3'd4: begin
                    case (cpu_addr[1:0])
                        2'd0:    m_port = {3'b111, cab_1p[1:0], service, coin[1:0]};
                        2'd1:    m_port = {2'b11, joystick1[5:0]};
                        2'd2:    m_port = {2'b11, joystick2[5:0]};
                        default: m_port = {2'b11, joystick1[6], joystick2[6], dipsw[19:16]};
                    endcase
                end
                3'd5: m_port = cpu_addr[0] ? dipsw[15:8] : dipsw[7:0];
                3'd6: m_rmrd = cpu_dout[0];
                3'd7: m_init = cpu_dout[0];
                default: ;
            endcase
        end
        m_busrst = rst8;
    endtask

    task automatic check_cycle();
        chip_sel_t s;
        s = model_sel();
        check_sel(s);
        check_rom(model_rom(s));
        check_byte(cpu_din, model_din(s), "cpu_din");
        check_byte({2'b00, dtack, init, rmrd, prio, snd_irq},
                   {2'b00, !s.rom || rom_ok, m_init, m_rmrd, m_prio, m_irq},
                   "dtack/init/rmrd/prio/snd_irq");
        check_byte(snd_latch, m_latch, "snd_latch");
        update_model(s);
    endtask

    // One bus access held for two cycles with a random cen in each
    task automatic run_access(input board_t b, input logic video_rst);
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] f;
        logic [15:0] a;
        r = next_rand();
        d = next_rand();
        e = next_rand();
        f = next_rand();
        if (r[2:0] < 3'd3) begin
            a = (b == ALIENS) ? {11'h2fc, r[20:16]} : {9'h03f, r[22:16]};  // I/O block
        end else if (r[2:0] == 3'd3) begin
            a = (b == ALIENS) ? {3'b001, r[28:16]} : {3'b011, r[28:16]};   // Bank window
        end else begin
            a = r[31:16];
        end
        repeat (2) begin
            @(posedge clk);
            board        <= b;
            rst8         <= video_rst;
            cpu_addr     <= a;
            cpu_aupper   <= r[15:8];
            cpu_we       <= r[3];
            cpu_dout     <= d[7:0];
            cpu_cen      <= next_rand() < 32'h4000_0000;
            rom_data     <= d[15:8];
            ram_dout     <= d[23:16];
            pal_dout     <= d[31:24];
            tilesys_dout <= e[7:0];
            objsys_dout  <= e[15:8];
            coin         <= e[19:16];
            cab_1p       <= e[23:20];
            joystick1    <= e[30:24];
            service      <= e[31];
            joystick2    <= f[6:0];
            dipsw        <= f[26:7];
            rom_ok       <= f[27];
            @(negedge clk);
            check_cycle();
        end
    endtask

    initial begin
        rst = 1'b1;
        rst8 = 1'b0;
        board = ALIENS;
        {cpu_cen, cpu_we, rom_ok, service} = 4'b0000;
        cpu_addr = '0;
        cpu_aupper = '0;
        {cpu_dout, rom_data, ram_dout, pal_dout, tilesys_dout, objsys_dout} = '0;
        {coin, cab_1p, joystick1, joystick2, dipsw} = '0;
        {m_init, m_rmrd, m_work, m_irq, m_busrst} = 5'b00000;
        m_bank = '0;
        m_prio = '0;
        m_latch = '0;
        m_port = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        // Both boards and then both again with video reset pulses
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < N_ACC; i++) begin
                run_access(p[0] ? SCONTRA : ALIENS, p >= 2 && i % 16 >= 12);
            end
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/main_board.sv
`default_nettype none

`include "main_cfg.svh"

module main_board (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rst8,       // Video side reset
    input  main_pkg::board_t        board,
    // CPU bus
    input  logic                    cpu_cen,
    input  logic [`MAIN_AW-1:0]     cpu_addr,
    input  logic [7:0]              cpu_aupper,
    input  logic [`MAIN_DW-1:0]     cpu_dout,
    input  logic                    cpu_we,
    output logic [`MAIN_DW-1:0]     cpu_din,
    output logic                    dtack,
    // ROM
    output logic [`MAIN_ROM_AW-1:0] rom_addr,
    output logic                    rom_cs,
    input  logic [`MAIN_DW-1:0]     rom_data,
    input  logic                    rom_ok,
    // Work RAM and palette
    output logic                    ram_we,
    input  logic [`MAIN_DW-1:0]     ram_dout,
    output logic                    pal_we,
    input  logic [`MAIN_DW-1:0]     pal_dout,
    // Video chips
    output logic                    tilesys_cs,
    input  logic [`MAIN_DW-1:0]     tilesys_dout,
    output logic                    objsys_cs,
    input  logic [`MAIN_DW-1:0]     objsys_dout,
    output logic                    init,
    output logic                    rmrd,
    output logic [1:0]              prio,
    // Sound
    output logic                    snd_irq,
    output logic [`MAIN_DW-1:0]     snd_latch,
    // Cabinet
    input  logic [3:0]              coin,
    input  logic [3:0]              cab_1p,
    input  logic [`MAIN_JOY_W-1:0]  joystick1,
    input  logic [`MAIN_JOY_W-1:0]  joystick2,
    input  logic                    service,
    input  logic [19:0]             dipsw
);
    import main_pkg::*;

    chip_sel_t           sel;
    logic                rst_cmb;
    logic                work;
    logic [3:0]          bank;
    logic [`MAIN_DW-1:0] port_in;

    cpu_bus_if bus ();

    assign bus.addr   = cpu_addr;
    assign bus.aupper = cpu_aupper;
    assign bus.dout   = cpu_dout;
    assign bus.we     = cpu_we;
    assign bus.cen    = cpu_cen;

    // Either reset source holds the CPU bus, one clock late
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rst_cmb <= 1'b1;
        end else begin
            rst_cmb <= rst8;
        end
    end

    addr_decode u_decode (
        .bus      (bus),
        .board    (board),
        .init     (init),
        .rmrd     (rmrd),
        .work     (work),
        .bank     (bank),
        .bus_rst  (rst_cmb),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    io_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .board     (board),
        .sel       (sel),
        .coin      (coin),
        .cab_1p    (cab_1p),
        .joystick1 (joystick1),
        .joystick2 (joystick2),
        .service   (service),
        .dipsw     (dipsw),
        .init      (init),
        .rmrd      (rmrd),
        .work      (work),
        .prio      (prio),
        .bank      (bank),
        .snd_latch (snd_latch),
        .snd_irq   (snd_irq),
        .port_in   (port_in)
    );

    read_mux u_mux (
        .sel          (sel),
        .rom_data     (rom_data),
        .ram_dout     (ram_dout),
        .port_in      (port_in),
        .pal_dout     (pal_dout),
        .tilesys_dout (tilesys_dout),
        .objsys_dout  (objsys_dout),
        .cpu_din      (cpu_din)
    );

    assign rom_cs     = sel.rom;
    assign tilesys_cs = sel.tile;
    assign objsys_cs  = sel.obj;
    assign ram_we     = sel.ram & cpu_we;
    assign pal_we     = sel.pal & cpu_we;
    assign dtack      = ~rom_cs | rom_ok;   // Wait only on a pending ROM fetch

endmodule

`default_nettype wire

//--- design/read_mux.sv
`default_nettype none

`include "main_cfg.svh"

module read_mux (
    input  main_pkg::chip_sel_t  sel,
    input  logic [`MAIN_DW-1:0]  rom_data,
    input  logic [`MAIN_DW-1:0]  ram_dout,
    input  logic [`MAIN_DW-1:0]  port_in,
    input  logic [`MAIN_DW-1:0]  pal_dout,
    input  logic [`MAIN_DW-1:0]  tilesys_dout,
    input  logic [`MAIN_DW-1:0]  objsys_dout,
    output logic [`MAIN_DW-1:0]  cpu_din
);

    // Fixed priority. On Aliens io sits inside the tile range,
    // so it has to win over tile
    always_comb begin
        if (sel.rom) begin
            cpu_din = rom_data;
        end else if (sel.ram) begin
            cpu_din = ram_dout;
        end else if (sel.io) begin
            cpu_din = port_in;
        end else if (sel.pal) begin
            cpu_din = pal_dout;
        end else if (sel.tile) begin
            cpu_din = tilesys_dout;
        end else if (sel.obj) begin
            cpu_din = objsys_dout;
        end else begin
            cpu_din = 8'hff;        // Open bus
        end
    end

endmodule

`default_nettype wire

//--- design/io_regs.sv
`default_nettype none

`include "main_cfg.svh"

module io_regs (
    input  logic                    clk,
    input  logic                    rst,
    cpu_bus_if.regs                 bus,
    input  main_pkg::board_t        board,
    input  main_pkg::chip_sel_t     sel,
    input  logic [3:0]              coin,
    input  logic [3:0]              cab_1p,
    input  logic [`MAIN_JOY_W-1:0]  joystick1,
    input  logic [`MAIN_JOY_W-1:0]  joystick2,
    input  logic                    service,
    input  logic [19:0]             dipsw,
    output logic                    init,
    output logic                    rmrd,
    output logic                    work,
    output logic [1:0]              prio,
    output logic [3:0]              bank,
    output logic [`MAIN_DW-1:0]     snd_latch,
    output logic                    snd_irq,
    output logic [`MAIN_DW-1:0]     port_in
);
    import main_pkg::*;

    // Super Contra register groups, picked by A4..A2
    typedef enum logic [2:0] {
        SC_CTRL  = 3'd0,
        SC_SND   = 3'd1,
        SC_IRQ   = 3'd2,
        SC_WDOG  = 3'd3,
        SC_INPUT = 3'd4,
        SC_DIPSW = 3'd5,
        SC_RMRD  = 3'd6,
        SC_INIT  = 3'd7
    } sc_reg_e;

    sc_reg_e             sc_grp;
    logic [`MAIN_DW-1:0] al_rd;
    logic [`MAIN_DW-1:0] sc_rd;

    assign sc_grp = sc_reg_e'(bus.addr[4:2]);

    // Aliens input ports
    always_comb begin
        case (bus.addr[3:0])
            4'h0:    al_rd = {3'b111, service, dipsw[19:16]};
            4'h1:    al_rd = {cab_1p[0], coin[0], joystick1[5:0]};
            4'h2:    al_rd = {cab_1p[1], coin[1], joystick2[5:0]};
            4'h3:    al_rd = dipsw[15:8];
            4'h4:    al_rd = dipsw[7:0];
            default: al_rd = 8'hff;
        endcase
    end

    // Super Contra input ports
    always_comb begin
        sc_rd = 8'hff;
        if (sc_grp == SC_INPUT) begin
            case (bus.addr[1:0])
                2'd0: sc_rd = {3'b111, cab_1p[1:0], service, coin[1:0]};
                2'd1: sc_rd = {2'b11, joystick1[5:0]};
                2'd2: sc_rd = {2'b11, joystick2[5:0]};
                2'd3: sc_rd = {2'b11, joystick1[6], joystick2[6], dipsw[19:16]};
            endcase
        end else if (sc_grp == SC_DIPSW) begin
            sc_rd = bus.addr[0] ? dipsw[15:8] : dipsw[7:0];
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            init      <= 1'b0;
            rmrd      <= 1'b0;
            work      <= 1'b0;
            prio      <= 2'b00;
            bank      <= 4'h0;
            snd_latch <= '0;
            snd_irq   <= 1'b0;
            port_in   <= '0;
        end else begin
            // Sound CPU sees a pulse, gone at the next CPU cycle
            if (bus.cen) snd_irq <= 1'b0;

            if (sel.io && board == ALIENS) begin
                if (bus.we) begin
                    case (bus.addr[3:0])
                        4'h8: {init, rmrd, work} <= bus.dout[7:5];  // Low bits drive coin counters
                        4'hc: begin
                            snd_latch <= bus.dout;
                            snd_irq   <= 1'b1;
                        end
                        default: ;
                    endcase
                end else begin
                    port_in <= al_rd;
                end
            end

            // No write strobe on this board, any access hits the latch
            if (sel.io && board == SCONTRA && !bus.addr[5]) begin
                case (sc_grp)
                    SC_CTRL: begin
                        prio         <= {1'b0, bus.dout[7]};
                        {work, bank} <= bus.dout[4:0];
                    end
                    SC_SND:             snd_latch <= bus.dout;
                    SC_IRQ:             snd_irq   <= 1'b1;
                    SC_INPUT, SC_DIPSW: port_in   <= sc_rd;
                    SC_RMRD:            rmrd      <= bus.dout[0];
                    SC_INIT:            init      <= bus.dout[0];
                    default: ;          // Watchdog
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/addr_decode.sv
`default_nettype none

`include "main_cfg.svh"

module addr_decode (
    cpu_bus_if.decoder                bus,
    input  main_pkg::board_t          board,
    input  logic                      init,
    input  logic                      rmrd,
    input  logic                      work,
    input  logic [3:0]                bank,
    input  logic                      bus_rst,
    output main_pkg::chip_sel_t       sel,
    output logic [`MAIN_ROM_AW-1:0]   rom_addr
);
    import main_pkg::*;

    logic [`MAIN_AW-1:0]     a;
    logic [7:0]              aupper;
    chip_sel_t               al_sel;
    chip_sel_t               sc_sel;
    logic                    al_banked;
    logic                    sc_banked;
    logic                    banked;
    logic [`MAIN_ROM_AW-1:0] al_rom;
    logic [`MAIN_ROM_AW-1:0] sc_rom;
    logic                    sc_hi;

    assign a      = bus.addr;
    assign aupper = bus.aupper;

    // Aliens map
    always_comb begin
        al_sel    = '0;
        al_banked = a[15:13] == 3'b001;                 // Window at 2000
        al_sel.rom = a[15] || al_banked;

        // Lowest 1kB swaps between work RAM and palette
        al_sel.ram = a[15:13] == 3'b000 && (a[12:10] != 3'b000 || !work);
        al_sel.pal = a[15:10] == 6'b000000 && work;

        al_sel.io  = a[15:5] == 11'h2fc;                // 5F80 to 5F9F
        al_sel.obj = a[15:11] == 5'b01111 && a[10] && init && !rmrd;

        // With init low the tile chip owns the whole 4000 block
        al_sel.tile = a[15:14] == 2'b01 &&
                      (!init || (!al_sel.io && !al_sel.obj));
    end

    // Super Contra map
    always_comb begin
        sc_sel    = '0;
        sc_banked = a[15:13] == 3'b011 && init;         // Window at 6000
        sc_sel.rom = a[15] || sc_banked;

        sc_sel.pal = a[15:11] == 5'b01011 && !work;     // 5800 to 5FFF
        sc_sel.ram = a[15:13] == 3'b010 && !sc_sel.pal;

        sc_sel.io  = a[15:7] == 9'h03f;                 // 1F80 to 1FFF
        sc_sel.obj = a[15:10] == 6'b001111 && !rmrd;

        // Low 16kB goes to the tile chip unless io or obj claim it
        sc_sel.tile = (a[15:14] == 2'b00 && !sc_sel.io && !sc_sel.obj) ||
                      (a[15:13] == 3'b011 && !init);
    end

    always_comb begin
        case (board)
            SCONTRA: begin
                sel    = sc_sel;
                banked = sc_banked;
            end
            default: begin
                sel    = al_sel;
                banked = al_banked;
            end
        endcase
        // No ROM access while the CPU is held in reset
        if (bus_rst) begin
            sel.rom = 1'b0;
        end
    end

    // Aliens takes the bank straight from the upper address byte
    assign al_rom = banked ? {aupper[4:0], a[12:0]} : {2'b10, a};

    // Super Contra bank comes from the board latch
    assign sc_hi = banked && bank[3];

    always_comb begin
        sc_rom[17]    = 1'b0;
        sc_rom[16]    = sc_hi;
        sc_rom[15]    = sc_hi ? bank[2] : a[15];
        sc_rom[14:13] = banked ? bank[1:0] : a[14:13];
        sc_rom[12:0]  = a[12:0];
    end

    always_comb begin
        rom_addr = (board == SCONTRA) ? sc_rom : al_rom;
        // Video chips share the low address lines
        if (!sel.rom) begin
            rom_addr[15:0] = a;
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_bus_if.sv
`default_nettype none

`include "main_cfg.svh"

interface cpu_bus_if;

    logic [`MAIN_AW-1:0] addr;
    logic [7:0]          aupper;    // Bank byte above the 16-bit address
    logic [`MAIN_DW-1:0] dout;      // CPU write data
    logic                we;        // Level, held with the address
    logic                cen;       // CPU clock enable

    // Address decoder only looks at the address lines
    modport decoder (
        input addr,
        input aupper
    );

    // Register block
    modport regs (
        input addr,
        input dout,
        input we,
        input cen
    );

endinterface

`default_nettype wire

//--- design/main_pkg.sv
`default_nettype none

package main_pkg;

    // Board variant, picked at run time from the top level
    typedef enum logic {
        ALIENS  = 1'b0,
        SCONTRA = 1'b1
    } board_t;

    // One bit per device on the main bus
    typedef struct packed {
        logic rom;
        logic ram;
        logic io;       // Cabinet ports and board latches
        logic pal;
        logic tile;     // Tile system chip
        logic obj;      // Object system chip
    } chip_sel_t;

endpackage

`default_nettype wire

//--- design/main_cfg.svh
`ifndef MAIN_CFG_SVH
`define MAIN_CFG_SVH

// CPU bus widths
`define MAIN_AW      16     // Low address, upper bank byte travels apart
`define MAIN_DW      8      // Data bus

// 18-bit ROM space, bank windows included
`define MAIN_ROM_AW  18

// Cabinet inputs
`define MAIN_JOY_W   7      // Per player, buttons and directions

`endif
